// ==== dv/harness_trace.txt ====
# op addr data be count (hex except count)
# w write, r read expecting data, g pulse gpio count times, i idle count, e intr_o equals data
w 0000 11223344 f 0
w 0000 aabbccdd 5 0
w 0004 deadbeef f 0
w 0004 00000000 c 0
w 0008 cafef00d f 0
r 0000 11bb33dd f 1
r 0004 0000beef f 1
r 0008 cafef00d f 1
r 100c 00000000 f 0
w 1000 00000005 f 0
i 0000 00000000 0 1
r 1004 00000000 f 0
i 0000 00000000 0 20
r 1004 00000005 f 0
g 0000 00000000 0 5
r 100c 00000005 f 0
e 0000 00000000 0 0
g 0000 00000000 0 3
r 100c 00000000 f 0
e 0000 00000001 0 0
r 1008 00000001 f 0
w 1008 00000001 f 0
e 0000 00000000 0 0
r 1010 00000000 f 0
w 1010 ffffffff f 0
w 1004 ffffffff f 0
w 100c ffffffff f 0
w 2000 ffffffff f 0
r 2000 00000000 f 1
r 1000 00000005 f 1
r 1004 00000005 f 1
r 1008 00000000 f 1
r 100c 00000000 f 1
r 0000 11bb33dd f 0

// ==== vlog.f ====
verilog/harness_bus_pkg.sv
verilog/harness_power_pkg.sv
verilog/delay_line.sv
verilog/slow_memory.sv
verilog/gpio_counter.sv
verilog/periph_ctrl.sv
verilog/harness_top.sv
dv/harness_tb.sv

// ==== Makefile ====
# Verilator build and run of the harness peripheral testbench

VERILATOR ?= verilator
TOP       ?= harness_tb
LOG       ?= sim.log

OBJ_DIR := obj_dir

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/harness_tb.sv ====
// Trace-driven testbench for the harness peripheral top level
// Replays bus, GPIO and idle operations and checks read data, latency and interrupt

module harness_tb;

  localparam int SEED         = 32'h95d0;
  localparam int CLK_HALF     = 2;
  localparam int RD_LATENCY   = 3;
  localparam int TIMEOUT_PAD  = 100;
  localparam int SWITCH_DELAY = 16;
  localparam int GPIO_WRAP    = 8;

  localparam logic [15:0] PWR_CTRL_ADDR = 16'h1000;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        req_i;
  logic        we_i;
  logic [15:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  be_i;
  logic        gpio_i;
  logic [31:0] rdata_o;
  logic        rvalid_o;
  logic        gpio_o;
  logic        intr_o;
  logic [2:0]  pwr_switch_n_o;
  logic [2:0]  pwr_ack_n_o;

  // Trace contents with one entry per operation
  logic [7:0]  tr_op   [$];
  logic [15:0] tr_addr [$];
  logic [31:0] tr_data [$];
  logic [3:0]  tr_be   [$];
  int          tr_cnt  [$];

  // Outstanding reads in request order
  logic [31:0] exp_data_q  [$];
  logic [15:0] exp_addr_q  [$];
  int          exp_cycle_q [$];

  // Expected switch requests and their acknowledges
  logic [2:0] exp_switch;
  logic [2:0] exp_ack;
  logic [2:0] switch_hist [$];

  int cycle         = 0;
  int timeout_limit = TIMEOUT_PAD;
  int checks        = 0;
  int errors        = 0;
  int pwr_cycles    = 0;
  int pwr_errors    = 0;
  int gpio_edges    = 0;
  int gpio_pulses   = 0;

  harness_top harness_top_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .rdata_o        (rdata_o),
    .rvalid_o       (rvalid_o),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .intr_o         (intr_o),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_ack_n_o    (pwr_ack_n_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // Cycle count and watchdog
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle > timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Power switch model
  // --------------------------------------------------------------------------
  // Acknowledge follows the request value held 16 edges earlier
  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_switch = '0;
      exp_ack    = '0;
      switch_hist.delete();
    end else begin
      switch_hist.push_back(exp_switch);
      if (switch_hist.size() == SWITCH_DELAY) begin
        exp_ack = switch_hist.pop_front();
      end
      if (req_i && we_i && addr_i == PWR_CTRL_ADDR) begin
        exp_switch = wdata_i[2:0];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read response monitor
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic [31:0] exp;
    logic [15:0] addr;
    int          lat;
    if (!reset_i && rvalid_o) begin
      if (exp_data_q.size() == 0) begin
        $display("error at %0t: read response arrived with no read outstanding", $time);
        errors++;
      end else begin
        exp  = exp_data_q.pop_front();
        addr = exp_addr_q.pop_front();
        lat  = cycle - exp_cycle_q.pop_front();
        checks++;
        if (rdata_o !== exp) begin
          $display("mismatch at %0t: read 0x%04h returned 0x%08h, expected 0x%08h",
                   $time, addr, rdata_o, exp);
          errors++;
        end else if (lat != RD_LATENCY) begin
          $display("mismatch at %0t: read 0x%04h took %0d cycles, expected %0d",
                   $time, addr, lat, RD_LATENCY);
          errors++;
        end else begin
          $display("read 0x%04h: 0x%08h after %0d cycles, ok", addr, rdata_o, lat);
        end
      end
    end
  end

  // Power outputs every cycle and GPIO wrap pulses
  always @(negedge clk_i) begin
    if (!reset_i) begin
      pwr_cycles++;
      if (pwr_switch_n_o !== exp_switch || pwr_ack_n_o !== exp_ack) begin
        $display("mismatch at %0t: switch_n 0x%0h ack_n 0x%0h, expected 0x%0h 0x%0h",
                 $time, pwr_switch_n_o, pwr_ack_n_o, exp_switch, exp_ack);
        pwr_errors++;
        errors++;
      end
      if (gpio_o === 1'b1) begin
        gpio_pulses++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks start and end on a falling edge
  // --------------------------------------------------------------------------
  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    be_i    = be;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic issue_read(input logic [15:0] addr, input logic [31:0] expected);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    be_i   = 4'hf;
    exp_data_q.push_back(expected);
    exp_addr_q.push_back(addr);
    exp_cycle_q.push_back(cycle);
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic pulse_gpio(input int count);
    gpio_edges += count;
    repeat (count) begin
      gpio_i = 1'b1;
      @(negedge clk_i);
      gpio_i = 1'b0;
      @(negedge clk_i);
    end
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) @(negedge clk_i);
  endtask

  task automatic check_intr(input logic expected);
    checks++;
    if (intr_o !== expected) begin
      $display("mismatch at %0t: intr_o is %b, expected %b", $time, intr_o, expected);
      errors++;
    end else begin
      $display("intr_o is %b, ok", intr_o);
    end
  endtask

  // Comment and blank lines fail to parse all five fields and are skipped
  task automatic load_trace;
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    int          cnt;
    fd = $fopen("dv/harness_trace.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open the trace file dv/harness_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%s %h %h %h %d", op, addr, data, be, cnt);
          if (n == 5) begin
            tr_op.push_back(op);
            tr_addr.push_back(addr);
            tr_data.push_back(data);
            tr_be.push_back(be);
            tr_cnt.push_back(cnt);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int gap;
    void'($urandom(SEED));
    reset_i = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    gpio_i  = 1'b0;

    load_trace();
    timeout_limit = TIMEOUT_PAD;
    foreach (tr_cnt[k]) begin
      timeout_limit += tr_cnt[k] + 3;
    end

    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    foreach (tr_op[k]) begin
      case (tr_op[k])
        "w": write_word(tr_addr[k], tr_data[k], tr_be[k]);
        "r": issue_read(tr_addr[k], tr_data[k]);
        "g": pulse_gpio(tr_cnt[k]);
        "i": wait_cycles(tr_cnt[k]);
        "e": check_intr(tr_data[k][0]);
        default: begin
          $display("error: unknown trace opcode 0x%02h in entry %0d", tr_op[k], k);
          errors++;
        end
      endcase
      // A bus operation with a nonzero count chains into the next cycle
      if (!((tr_op[k] == "w" || tr_op[k] == "r") && tr_cnt[k] != 0)) begin
        gap = $urandom % 3;
        wait_cycles(gap);
      end
    end

    while (exp_data_q.size() != 0) @(negedge clk_i);
    wait_cycles(RD_LATENCY + 1);

    checks++;
    if (pwr_errors == 0) begin
      $display("power outputs matched in %0d cycles, ok", pwr_cycles);
    end else begin
      $display("power outputs wrong in %0d of %0d cycles", pwr_errors, pwr_cycles);
    end

    checks++;
    if (gpio_pulses != gpio_edges / GPIO_WRAP) begin
      $display("mismatch at %0t: gpio_o high in %0d cycles, expected %0d",
               $time, gpio_pulses, gpio_edges / GPIO_WRAP);
      errors++;
    end else begin
      $display("gpio_o pulsed %0d times for %0d edges, ok", gpio_pulses, gpio_edges);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/harness_top.sv ====
// Harness peripheral top level
// Connects the control block to memory, GPIO counter and the delay lines

module harness_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Register bus
  input  logic                        req_i,
  input  logic                        we_i,
  input  harness_bus_pkg::addr_t      addr_i,
  input  harness_bus_pkg::data_t      wdata_i,
  input  harness_bus_pkg::be_t        be_i,
  output harness_bus_pkg::data_t      rdata_o,
  output logic                        rvalid_o,
  // GPIO and interrupt
  input  logic                        gpio_i,
  output logic                        gpio_o,
  output logic                        intr_o,
  // Power switches
  output harness_power_pkg::pwr_vec_t pwr_switch_n_o,
  output harness_power_pkg::pwr_vec_t pwr_ack_n_o
);

  import harness_bus_pkg::*;
  import harness_power_pkg::*;

  logic      mem_req;
  logic      mem_we;
  mem_addr_t mem_addr;
  data_t     mem_wdata;
  be_t       mem_be;
  data_t     mem_rdata;
  pwr_vec_t  switch_n;
  pwr_vec_t  ack_n;
  cnt_t      gpio_cnt;
  logic      gpio_wrap;
  rsp_t      rsp;
  rsp_t      rsp_d;

  periph_ctrl periph_ctrl_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_be_o    (mem_be),
    .mem_rdata_i (mem_rdata),
    .switch_n_o  (switch_n),
    .ack_n_i     (ack_n),
    .gpio_cnt_i  (gpio_cnt),
    .gpio_wrap_i (gpio_wrap),
    .intr_o      (intr_o),
    .rsp_o       (rsp)
  );

  slow_memory slow_memory_i (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  gpio_counter gpio_counter_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .gpio_i  (gpio_i),
    .cnt_o   (gpio_cnt),
    .wrap_o  (gpio_wrap)
  );

  // Power switch acknowledges
  delay_line #(
    .payload_t (pwr_vec_t),
    .DEPTH     (SWITCH_ACK_LATENCY)
  ) ack_delay_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_i    (switch_n),
    .out_o   (ack_n)
  );

  // Fixed-latency read responses
  delay_line #(
    .payload_t (rsp_t),
    .DEPTH     (RSP_PIPE_DEPTH)
  ) rsp_delay_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_i    (rsp),
    .out_o   (rsp_d)
  );

  assign rdata_o        = rsp_d.data;
  assign rvalid_o       = rsp_d.valid;
  assign gpio_o         = gpio_wrap;
  assign pwr_switch_n_o = switch_n;
  assign pwr_ack_n_o    = ack_n;

endmodule

// ==== verilog/periph_ctrl.sv ====
// Peripheral control block of the harness
// Decodes bus requests to memory or registers, emulates power switches
// and builds the read response

module periph_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Register bus
  input  logic                          req_i,
  input  logic                          we_i,
  input  harness_bus_pkg::addr_t        addr_i,
  input  harness_bus_pkg::data_t        wdata_i,
  input  harness_bus_pkg::be_t          be_i,
  // Slow memory
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output harness_bus_pkg::mem_addr_t    mem_addr_o,
  output harness_bus_pkg::data_t        mem_wdata_o,
  output harness_bus_pkg::be_t          mem_be_o,
  input  harness_bus_pkg::data_t        mem_rdata_i,
  // Power switches
  output harness_power_pkg::pwr_vec_t   switch_n_o,
  input  harness_power_pkg::pwr_vec_t   ack_n_i,
  // GPIO counter
  input  harness_power_pkg::cnt_t       gpio_cnt_i,
  input  logic                          gpio_wrap_i,
  // Outputs
  output logic                          intr_o,
  output harness_bus_pkg::rsp_t         rsp_o
);

  import harness_bus_pkg::*;
  import harness_power_pkg::*;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_MEM,
    TGT_REG
  } target_e;

  logic      is_mem;
  logic      is_reg;
  logic      reg_wr;
  data_t     reg_rdata;
  pwr_vec_t  switch_n_q;
  intr_vec_t intr_pending_q;
  logic      rd_valid_q;
  target_e   rd_target_q;
  data_t     reg_rdata_q;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  assign is_mem = (addr_i[ADDR_W-1:MEM_ADDR_W+2] == '0);
  assign is_reg = (addr_i[ADDR_W-1:12] == REG_BASE[ADDR_W-1:12]);
  assign reg_wr = req_i & we_i & is_reg & be_i[0];

  // Memory requests pass straight through
  assign mem_req_o   = req_i & is_mem;
  assign mem_we_o    = we_i;
  assign mem_addr_o  = addr_i[MEM_ADDR_W+1:2];
  assign mem_wdata_o = wdata_i;
  assign mem_be_o    = be_i;

  // --------------------------------------------------------------------------
  // Harness registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_n_q     <= '0;
      intr_pending_q <= '0;
    end else begin
      if (reg_wr && addr_i == REG_PWR_CTRL) begin
        switch_n_q <= wdata_i[PWR_DOMAINS-1:0];
      end
      // Write 1 clears; a wrap in the same cycle wins
      if (reg_wr && addr_i == REG_INTR) begin
        intr_pending_q <= intr_pending_q & ~wdata_i[INTR_BITS-1:0];
      end
      if (gpio_wrap_i) begin
        intr_pending_q[INTR_GPIO_BIT] <= 1'b1;
      end
    end
  end

  assign switch_n_o = switch_n_q;
  assign intr_o     = |intr_pending_q;

  // Register read mux, unmapped offsets read as zero
  always_comb begin
    reg_rdata = '0;
    case (addr_i)
      REG_PWR_CTRL:   reg_rdata[PWR_DOMAINS-1:0] = switch_n_q;
      REG_PWR_STATUS: reg_rdata[PWR_DOMAINS-1:0] = ack_n_i;
      REG_INTR:       reg_rdata[INTR_BITS-1:0] = intr_pending_q;
      REG_GPIO_CNT:   reg_rdata[$bits(cnt_t)-1:0] = gpio_cnt_i;
      default:        reg_rdata = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Read response stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_q  <= 1'b0;
      rd_target_q <= TGT_NONE;
    end else begin
      rd_valid_q  <= req_i & ~we_i;
      rd_target_q <= is_mem ? TGT_MEM : (is_reg ? TGT_REG : TGT_NONE);
    end
  end

  always_ff @(posedge clk_i) begin
    reg_rdata_q <= reg_rdata;
  end

  // Memory data lands in the same cycle as the registered target
  always_comb begin
    rsp_o.valid = rd_valid_q;
    case (rd_target_q)
      TGT_MEM: rsp_o.data = mem_rdata_i;
      TGT_REG: rsp_o.data = reg_rdata_q;
      default: rsp_o.data = '0;
    endcase
  end

endmodule

// ==== verilog/gpio_counter.sv ====
// GPIO rising-edge counter
// Wraps to zero after GPIO_CNT_MAX edges and pulses wrap_o for one cycle

module gpio_counter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    gpio_i,
  output harness_power_pkg::cnt_t cnt_o,
  output logic                    wrap_o
);

  import harness_power_pkg::*;

  logic gpio_q;
  logic rise;
  cnt_t cnt_q;
  logic wrap_q;

  // Input sampled once for edge detection
  assign rise = gpio_i & ~gpio_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_q <= 1'b0;
      cnt_q  <= '0;
      wrap_q <= 1'b0;
    end else begin
      gpio_q <= gpio_i;
      wrap_q <= 1'b0;
      if (rise) begin
        if (cnt_q == cnt_t'(GPIO_CNT_MAX - 1)) begin
          cnt_q  <= '0;
          wrap_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + cnt_t'(1);
        end
      end
    end
  end

  assign cnt_o  = cnt_q;
  assign wrap_o = wrap_q;

endmodule

// ==== verilog/slow_memory.sv ====
// Word-addressed slow memory with byte-enable writes
// Read data appears one cycle after the request

module slow_memory (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  harness_bus_pkg::mem_addr_t addr_i,
  input  harness_bus_pkg::data_t     wdata_i,
  input  harness_bus_pkg::be_t       be_i,
  output harness_bus_pkg::data_t     rdata_o
);

  import harness_bus_pkg::*;

  data_t mem_q [MEM_WORDS];
  data_t rdata_q;

  // --------------------------------------------------------------------------
  // Write port
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------
  // Holds the last word read between requests
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== verilog/delay_line.sv ====
// Fixed-depth register pipeline for an arbitrary payload type
// Every stage clears on reset, so several items may be in flight

module delay_line #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t in_i,
  output payload_t out_o
);

  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out_o = stage_q[DEPTH-1];

endmodule

// ==== verilog/harness_power_pkg.sv ====
// Power switch emulation and GPIO counter definitions

package harness_power_pkg;

  // Domains in bit order: cpu, peripheral, external
  localparam int unsigned PWR_DOMAINS = 3;
  typedef logic [PWR_DOMAINS-1:0] pwr_vec_t;

  // Cycles from a switch request to its acknowledge
  localparam int unsigned SWITCH_ACK_LATENCY = 16;

  // GPIO edge counter
  localparam int unsigned GPIO_CNT_MAX = 8;
  typedef logic [15:0] cnt_t;

  // Interrupt pending register layout
  localparam int unsigned INTR_GPIO_BIT = 0;
  localparam int unsigned INTR_BITS     = 1;
  typedef logic [INTR_BITS-1:0] intr_vec_t;

endpackage

// ==== verilog/harness_bus_pkg.sv ====
// Harness register bus definitions
// Widths, address map and the read response word

package harness_bus_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  // Slow memory occupies 0x0000 to 0x0FFF
  localparam int unsigned MEM_WORDS  = 1024;
  localparam int unsigned MEM_ADDR_W = $clog2(MEM_WORDS);
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // Harness register window, 4 KiB wide
  localparam addr_t REG_BASE       = 16'h1000;
  localparam addr_t REG_PWR_CTRL   = 16'h1000;
  localparam addr_t REG_PWR_STATUS = 16'h1004;
  localparam addr_t REG_INTR       = 16'h1008;
  localparam addr_t REG_GPIO_CNT   = 16'h100C;

  // --------------------------------------------------------------------------
  // Read response path
  // --------------------------------------------------------------------------
  localparam int unsigned RSP_PIPE_DEPTH = 2;
  // One stage in the control block plus the response delay line
  localparam int unsigned READ_LATENCY   = 1 + RSP_PIPE_DEPTH;

  typedef struct packed {
    logic  valid;
    data_t data;
  } rsp_t;

endpackage
